// File: hw/fxp_pkg.sv
// numeric format of the datapath
// signed Qm.n words, here Q1.14
package fxp_pkg;

  // word layout
  localparam int WORD_SIZE = 16; // bits per datapath word
  localparam int N_SIZE    = 14; // fraction bits
  localparam int M_SIZE    = 1;  // integer bits, sign not counted

  // one datapath word, Q1.14
  typedef logic signed [WORD_SIZE-1:0] fxp_word_t;

  // saturation limits
  localparam fxp_word_t FXP_MAX = {1'b0, {(WORD_SIZE-1){1'b1}}}; // 0x7fff, just under +2.0
  localparam fxp_word_t FXP_MIN = {1'b1, {(WORD_SIZE-1){1'b0}}}; // 0x8000, -2.0

  // unity
  localparam fxp_word_t FXP_ONE = fxp_word_t'(1) <<< N_SIZE; // 0x4000

endpackage

// File: hw/filt_pkg.sv
// filter control registers
// address map, reset values, control bits
package filt_pkg;

  // register address, four slots and three in use
  typedef logic [1:0] reg_addr_t;

  // address map
  localparam reg_addr_t ADDR_ALPHA = 2'd0; // smoothing coefficient
  localparam reg_addr_t ADDR_GAIN  = 2'd1; // output gain
  localparam reg_addr_t ADDR_CTRL  = 2'd2; // control bits
  // slot 3 is unmapped

  // control register bit positions
  localparam int CTRL_INVERT = 0; // negate the output

  // coefficient reset values
  localparam fxp_pkg::fxp_word_t ALPHA_RESET = 16'sh1000;      // 0.25
  localparam fxp_pkg::fxp_word_t GAIN_RESET  = fxp_pkg::FXP_ONE; // unity gain

endpackage

// File: hw/safe_alu.sv
`timescale 1ns/1ns

// saturating fixed point arithmetic, combinational
// OPERATION picks one of
//   "add"  : a + b
//   "sub"  : a - b
//   "mult" : (a * b) >>> N_SIZE, truncated
//   "comp" : -a, b unused
// every result clamps to FXP_MIN / FXP_MAX instead of wrapping
module safe_alu #(
  parameter string OPERATION = "add"
) (
  input  fxp_pkg::fxp_word_t a_i,
  input  fxp_pkg::fxp_word_t b_i,
  output fxp_pkg::fxp_word_t data_o
);

  import fxp_pkg::*;

  generate
    case (OPERATION)

      "add": begin : g_add
        logic signed [WORD_SIZE:0] sum; // one guard bit

        always_comb begin
          sum = a_i + b_i;
          // top two bits disagree -> out of range
          case (sum[WORD_SIZE -: 2])
            2'b10:   data_o = FXP_MIN; // underflow
            2'b01:   data_o = FXP_MAX; // overflow
            default: data_o = sum[WORD_SIZE-1:0];
          endcase
        end
      end

      "sub": begin : g_sub
        logic signed [WORD_SIZE:0] diff; // one guard bit

        always_comb begin
          diff = a_i - b_i;
          case (diff[WORD_SIZE -: 2])
            2'b10:   data_o = FXP_MIN; // underflow
            2'b01:   data_o = FXP_MAX; // overflow
            default: data_o = diff[WORD_SIZE-1:0];
          endcase
        end
      end

      "mult": begin : g_mult
        localparam int MSB = 2*WORD_SIZE-1;
        localparam int TOP = MSB-(M_SIZE+1); // msb of the kept slice
        logic signed [2*WORD_SIZE-1:0] prod; // full Q3.28 product
        logic                          neg_big; // below -2.0
        logic                          pos_big; // at or above +2.0

        always_comb begin
          prod    = a_i * b_i;
          // bits above the kept slice must all copy the sign
          neg_big = prod[MSB] && !(&prod[MSB-1:TOP]);
          pos_big = !prod[MSB] && (|prod[MSB-1:TOP]);
          if (neg_big)
            data_o = FXP_MIN;
          else if (pos_big)
            data_o = FXP_MAX;
          else
            data_o = prod[TOP:N_SIZE]; // fraction truncated
        end
      end

      "comp": begin : g_comp
        always_comb begin
          // -(-2.0) does not fit, pin to max
          if (a_i == FXP_MIN)
            data_o = FXP_MAX;
          else
            data_o = -a_i;
        end
      end

      default: begin : g_bad_op
        $error("safe_alu: unknown OPERATION %s", OPERATION);
        assign data_o = '0;
      end

    endcase
  endgenerate

endmodule

// File: hw/coef_regs.sv
`timescale 1ns/1ns

// coefficient bank, loaded by a single cycle write strobe
// alpha feeds the ema stage, gain and invert the gain stage
module coef_regs (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                wr_en_i,
  input  filt_pkg::reg_addr_t wr_addr_i,
  input  fxp_pkg::fxp_word_t  wr_data_i,
  output fxp_pkg::fxp_word_t  alpha_o,
  output fxp_pkg::fxp_word_t  gain_o,
  output logic                invert_o
);

  import fxp_pkg::*;
  import filt_pkg::*;

  fxp_word_t alpha_q;  // smoothing factor
  fxp_word_t gain_q;   // output gain
  logic      invert_q; // ctrl invert bit

  // write lands on the strobe edge, next sample sees it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alpha_q  <= ALPHA_RESET;
      gain_q   <= GAIN_RESET;
      invert_q <= 1'b0;
    end else if (wr_en_i) begin
      case (wr_addr_i)
        ADDR_ALPHA: alpha_q  <= wr_data_i;
        ADDR_GAIN:  gain_q   <= wr_data_i;
        ADDR_CTRL:  invert_q <= wr_data_i[CTRL_INVERT]; // other ctrl bits dropped
        default: ; // slot 3, nothing there
      endcase
    end
  end

  assign alpha_o  = alpha_q;
  assign gain_o   = gain_q;
  assign invert_o = invert_q;

  // a write must target a known slot, else a register goes X
  a_wr_addr_known : assert property (
    @(posedge clk_i) disable iff (reset_i)
    wr_en_i |-> !$isunknown(wr_addr_i)
  ) else $error("coef_regs: write with unknown address");

endmodule

// File: hw/ema_stage.sv
`timescale 1ns/1ns

// one pole smoother, y <= y + alpha * (x - y)
// new y registered on the sample strobe, shown one cycle later
module ema_stage (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               clear_i,
  input  logic               sample_valid_i,
  input  fxp_pkg::fxp_word_t sample_i,
  input  fxp_pkg::fxp_word_t alpha_i,
  output logic               ema_valid_o,
  output fxp_pkg::fxp_word_t ema_data_o
);

  import fxp_pkg::*;

  fxp_word_t y_q;     // filter state
  fxp_word_t y_base;  // state as seen this cycle, zero on clear
  fxp_word_t delta;   // x - y
  fxp_word_t step;    // alpha * (x - y)
  fxp_word_t y_next;  // y + step
  logic      valid_q;

  // clear on the same edge as a sample -> start from zero
  assign y_base = clear_i ? '0 : y_q;

  safe_alu #(.OPERATION("sub")) u_sub (
    .a_i    (sample_i),
    .b_i    (y_base),
    .data_o (delta)
  );

  safe_alu #(.OPERATION("mult")) u_mult (
    .a_i    (alpha_i),
    .b_i    (delta),
    .data_o (step)
  );

  safe_alu #(.OPERATION("add")) u_add (
    .a_i    (y_base),
    .b_i    (step),
    .data_o (y_next)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      y_q     <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= sample_valid_i; // one cycle pulse
      if (sample_valid_i)
        y_q <= y_next;
      else if (clear_i)
        y_q <= '0; // clear alone just drops the state
    end
  end

  assign ema_valid_o = valid_q;
  assign ema_data_o  = y_q; // y doubles as the stage output

  // valid must be clean once out of reset, gain stage keys on it
  a_valid_known : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !$isunknown(ema_valid_o)
  ) else $error("ema_stage: ema_valid_o unknown");

endmodule

// File: hw/gain_stage.sv
`timescale 1ns/1ns

// output gain with optional saturating negation
// result registered on ema_valid_i, out_valid_o pulses one cycle later
module gain_stage (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               ema_valid_i,
  input  fxp_pkg::fxp_word_t ema_data_i,
  input  fxp_pkg::fxp_word_t gain_i,
  input  logic               invert_i,
  output logic               out_valid_o,
  output fxp_pkg::fxp_word_t out_data_o
);

  import fxp_pkg::*;

  fxp_word_t scaled;     // gain * y
  fxp_word_t scaled_neg; // -(gain * y), saturated
  fxp_word_t data_q;
  logic      valid_q;

  safe_alu #(.OPERATION("mult")) u_mult (
    .a_i    (gain_i),
    .b_i    (ema_data_i),
    .data_o (scaled)
  );

  // -2.0 product comes out as FXP_MAX
  safe_alu #(.OPERATION("comp")) u_neg (
    .a_i    (scaled),
    .b_i    ('0), // single operand op
    .data_o (scaled_neg)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i)
      valid_q <= 1'b0;
    else
      valid_q <= ema_valid_i;
  end

  // gain and invert taken as they stand on this edge
  always_ff @(posedge clk_i) begin
    if (ema_valid_i)
      data_q <= invert_i ? scaled_neg : scaled;
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  // each valid pulse comes out one cycle later with a defined word
  a_valid_follows : assert property (
    @(posedge clk_i) disable iff (reset_i)
    ema_valid_i |=> out_valid_o && !$isunknown(out_data_o)
  ) else $error("gain_stage: no clean output one cycle after ema_valid_i");

endmodule

// File: hw/fxp_filter_top.sv
`timescale 1ns/1ns

// smoothing filter top
// coef bank -> ema stage -> gain stage, two cycles sample to output
module fxp_filter_top (
  input  logic                clk_i,
  input  logic                reset_i,
  // coefficient writes
  input  logic                wr_en_i,
  input  filt_pkg::reg_addr_t wr_addr_i,
  input  fxp_pkg::fxp_word_t  wr_data_i,
  // sample stream
  input  logic                sample_valid_i,
  input  fxp_pkg::fxp_word_t  sample_i,
  input  logic                clear_i,
  // results
  output logic                out_valid_o,
  output fxp_pkg::fxp_word_t  out_data_o
);

  import fxp_pkg::*;

  fxp_word_t alpha;     // to stage 1
  fxp_word_t gain;      // to stage 2
  logic      invert;    // to stage 2
  logic      ema_valid; // stage 1 -> stage 2
  fxp_word_t ema_data;

  coef_regs u_coef_regs (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .alpha_o   (alpha),
    .gain_o    (gain),
    .invert_o  (invert)
  );

  ema_stage u_ema_stage (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .clear_i        (clear_i),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .alpha_i        (alpha),
    .ema_valid_o    (ema_valid),
    .ema_data_o     (ema_data)
  );

  gain_stage u_gain_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ema_valid_i (ema_valid),
    .ema_data_i  (ema_data),
    .gain_i      (gain),
    .invert_i    (invert),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o)
  );

endmodule

// File: tb/fxp_model.svh
`ifndef FXP_MODEL_SVH
`define FXP_MODEL_SVH

// reference model of the smoothing filter
// included inside the testbench module, after the package imports

fxp_word_t m_y;           // model state y
fxp_word_t m_alpha;
fxp_word_t m_gain;
logic      m_invert;
logic      m_st1_valid;   // a sample sits between the two stages
fxp_word_t m_st1_y;
int        m_st1_due;     // cycle count at which its output is checked
fxp_word_t exp_data_q[$]; // expected outputs, oldest first
int        exp_due_q[$];

// pin anything out of range to the rails
function automatic fxp_word_t clamp_word(input int v);
  if (v > int'(FXP_MAX))
    return FXP_MAX;
  if (v < int'(FXP_MIN))
    return FXP_MIN;
  return fxp_word_t'(v[WORD_SIZE-1:0]);
endfunction

function automatic fxp_word_t sat_add(input fxp_word_t a, input fxp_word_t b);
  return clamp_word(int'(a) + int'(b));
endfunction

function automatic fxp_word_t sat_sub(input fxp_word_t a, input fxp_word_t b);
  return clamp_word(int'(a) - int'(b));
endfunction

function automatic fxp_word_t sat_mul(input fxp_word_t a, input fxp_word_t b);
  int p;
  p = int'(a) * int'(b);          // at most 2^30, fits
  return clamp_word(p >>> N_SIZE); // floor shift, fraction dropped
endfunction

function automatic fxp_word_t sat_neg(input fxp_word_t a);
  return clamp_word(-int'(a)); // -(-2.0) lands on max
endfunction

function automatic void model_reset();
  m_y         = '0;
  m_alpha     = ALPHA_RESET;
  m_gain      = GAIN_RESET;
  m_invert    = 1'b0;
  m_st1_valid = 1'b0;
  m_st1_y     = '0;
  m_st1_due   = 0;
  exp_data_q.delete();
  exp_due_q.delete();
endfunction

// one rising edge, every register sees the values from before it
function automatic void model_edge(input logic we, input reg_addr_t addr,
                                   input fxp_word_t wdata, input logic sv,
                                   input fxp_word_t x, input logic clr, input int cycle);
  fxp_word_t base;
  fxp_word_t prod;
  if (m_st1_valid) begin
    prod = sat_mul(m_gain, m_st1_y); // gain as it stands before this edge
    exp_data_q.push_back(m_invert ? sat_neg(prod) : prod);
    exp_due_q.push_back(m_st1_due);
  end
  m_st1_valid = sv;
  if (sv) begin
    base      = clr ? fxp_word_t'(0) : m_y; // clear on the sample edge
    m_y       = sat_add(base, sat_mul(m_alpha, sat_sub(x, base)));
    m_st1_y   = m_y;
    m_st1_due = cycle + 1; // seen on the falling edge after the next edge
  end else if (clr) begin
    m_y = '0;
  end
  if (we) begin
    case (addr)
      ADDR_ALPHA: m_alpha  = wdata;
      ADDR_GAIN:  m_gain   = wdata;
      ADDR_CTRL:  m_invert = wdata[CTRL_INVERT];
      default: ; // slot 3 holds nothing
    endcase
  end
endfunction

`endif

// File: tb/tb_fxp_filter.sv
`timescale 1ns/1ns

module tb_fxp_filter;

  import fxp_pkg::*;
  import filt_pkg::*;

  `include "fxp_model.svh"

  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_LIMIT  = 20; // far more than the 2 cycle pipe

  logic      clk_i = 1'b0;
  logic      reset_i;
  logic      wr_en_i;
  reg_addr_t wr_addr_i;
  fxp_word_t wr_data_i;
  logic      sample_valid_i;
  fxp_word_t sample_i;
  logic      clear_i;
  logic      out_valid_o;
  fxp_word_t out_data_o;

  int        seed      = 32'h90b0e32f;
  int        cycle_cnt = 0; // rising edges so far
  int        error_cnt = 0;
  int        check_cnt = 0;
  int        test_cnt  = 0;
  int        fail_cnt  = 0;
  int        test_err0 = 0; // errors when the current test began
  int        out_cnt   = 0; // output pulses seen
  fxp_word_t last_out;

  fxp_filter_top dut_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .wr_en_i        (wr_en_i),
    .wr_addr_i      (wr_addr_i),
    .wr_data_i      (wr_data_i),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .clear_i        (clear_i),
    .out_valid_o    (out_valid_o),
    .out_data_o     (out_data_o)
  );

  always #50 clk_i = ~clk_i; // 100 ns period

  task automatic check_value(input string what, input int got, input int want);
    check_cnt++;
    if (got != want) begin
      error_cnt++;
      $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic report_failure(input string what);
    error_cnt++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  // model steps on the same edges as the DUT
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (reset_i)
      model_reset();
    else
      model_edge(wr_en_i, wr_addr_i, wr_data_i, sample_valid_i, sample_i, clear_i, cycle_cnt);
  end

  // outputs settle after the rising edge, look at them on the falling one
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (out_valid_o) begin
        out_cnt++;
        last_out = out_data_o;
        if (exp_data_q.size() == 0) begin
          report_failure("output pulse with no sample behind it");
        end else begin
          check_value("output cycle", cycle_cnt, exp_due_q[0]);
          check_value("out_data_o", int'(out_data_o), int'(exp_data_q[0]));
          exp_data_q.delete(0);
          exp_due_q.delete(0);
        end
      end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle_cnt) begin
        report_failure("an expected output never came");
        exp_data_q.delete(0);
        exp_due_q.delete(0);
      end
    end
  end

  function automatic fxp_word_t rand_word();
    int r;
    r = $random(seed);
    return fxp_word_t'(r[15:0]);
  endfunction

  function automatic logic rand_bit(input int one_in); // true about once in one_in
    int r;
    r = $random(seed);
    return ((r & 255) % one_in) == 0;
  endfunction

  // one cycle of inputs, set just after the falling edge
  task automatic drive_cycle(input logic we, input reg_addr_t addr, input fxp_word_t wd,
                             input logic sv, input fxp_word_t x, input logic clr);
    @(negedge clk_i);
    wr_en_i        = we;
    wr_addr_i      = addr;
    wr_data_i      = wd;
    sample_valid_i = sv;
    sample_i       = x;
    clear_i        = clr;
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, ADDR_ALPHA, '0, 1'b0, '0, 1'b0);
  endtask

  task automatic send_sample(input fxp_word_t x);
    drive_cycle(1'b0, ADDR_ALPHA, '0, 1'b1, x, 1'b0);
  endtask

  task automatic write_reg(input reg_addr_t addr, input fxp_word_t wd);
    drive_cycle(1'b1, addr, wd, 1'b0, '0, 1'b0);
  endtask

  // idle until every expected output has been seen
  task automatic drain_outputs();
    int waited;
    waited = 0;
    idle_cycle();
    while ((exp_data_q.size() != 0 || m_st1_valid) && waited < DRAIN_LIMIT) begin
      idle_cycle();
      waited++;
    end
    if (exp_data_q.size() != 0 || m_st1_valid)
      report_failure($sformatf("outputs still pending after %0d idle cycles", DRAIN_LIMIT));
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (error_cnt == test_err0) begin
      $display("test %0d %s: pass", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: FAIL with %0d errors", test_cnt, name, error_cnt - test_err0);
    end
    test_err0 = error_cnt;
  endtask

  initial begin
    int        i;
    int        r;
    int        outs0;
    logic      we;
    logic      sv;
    reg_addr_t a;
    fxp_word_t wd;
    fxp_word_t x;
    reset_i        = 1'b1;
    wr_en_i        = 1'b0;
    wr_addr_i      = '0;
    wr_data_i      = '0;
    sample_valid_i = 1'b0;
    sample_i       = '0;
    clear_i        = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    check_value("out_valid_o after reset", int'(out_valid_o), 0);
    for (i = 0; i < 48; i++) begin
      if (rand_bit(3))
        idle_cycle();
      else
        send_sample(rand_word());
    end
    drain_outputs();
    end_test("reset coefficients");

    // writes to alpha, gain and the empty slot, mixed with samples
    for (i = 0; i < 120; i++) begin
      r  = $random(seed);
      we = rand_bit(4);
      sv = !rand_bit(3);
      a  = reg_addr_t'(r[1:0]);
      if (a == ADDR_CTRL)
        a = 2'd3; // invert gets its own test
      wd = rand_word();
      x  = rand_word();
      drive_cycle(we, a, wd, sv, x, 1'b0);
    end
    write_reg(2'd3, FXP_MIN);
    for (i = 0; i < 8; i++)
      send_sample(rand_word());
    drain_outputs();
    end_test("coefficient writes");

    write_reg(ADDR_ALPHA, FXP_ONE);
    write_reg(ADDR_GAIN, FXP_MAX);
    send_sample(FXP_MAX);
    send_sample(FXP_MAX); // y near max now, whatever it was before
    drain_outputs();
    check_value("max sample at gain near +2", int'(last_out), int'(FXP_MAX));
    write_reg(ADDR_GAIN, FXP_MIN);
    send_sample(FXP_MIN);
    send_sample(FXP_MIN); // y reaches -2.0 here
    drain_outputs();
    check_value("-2.0 times -2.0", int'(last_out), int'(FXP_MAX));
    for (i = 0; i < 40; i++) begin
      r  = $random(seed);
      we = r[2];
      a  = r[3] ? ADDR_GAIN : ADDR_ALPHA;
      wd = r[3] ? fxp_word_t'({r[4], {14{~r[4]}}, r[5]}) : FXP_ONE; // gains near +-2
      x  = r[6] ? FXP_MAX : FXP_MIN;
      drive_cycle(we, a, wd, 1'b1, x, 1'b0);
    end
    drain_outputs();
    end_test("saturation");

    write_reg(ADDR_CTRL, 16'sh0001);
    for (i = 0; i < 40; i++) begin
      we = rand_bit(5);
      wd = rand_word();
      x  = rand_word();
      drive_cycle(we, ADDR_GAIN, wd, 1'b1, x, 1'b0);
    end
    write_reg(ADDR_ALPHA, FXP_ONE);
    write_reg(ADDR_GAIN, FXP_ONE);
    drive_cycle(1'b0, ADDR_ALPHA, '0, 1'b1, FXP_MIN, 1'b1); // y and product both -2.0
    drain_outputs();
    check_value("negated -2.0", int'(last_out), int'(FXP_MAX));
    write_reg(ADDR_CTRL, '0);
    end_test("inverted output");

    write_reg(ADDR_ALPHA, ALPHA_RESET);
    for (i = 0; i < 60; i++) begin
      sv = !rand_bit(3);
      we = rand_bit(6); // clear strobe here
      x  = rand_word();
      drive_cycle(1'b0, ADDR_ALPHA, '0, sv, x, we);
    end
    send_sample(FXP_MAX);
    drive_cycle(1'b0, ADDR_ALPHA, '0, 1'b1, FXP_ONE, 1'b1); // 0 + 0.25 * 1.0
    drain_outputs();
    check_value("sample on the clear edge", int'(last_out), 16'sh1000);
    end_test("clear");

    outs0 = out_cnt;
    for (i = 0; i < 32; i++)
      send_sample(rand_word());
    drain_outputs();
    check_value("outputs for 32 back to back samples", out_cnt - outs0, 32);
    end_test("back to back");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, fail_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+tb
hw/fxp_pkg.sv
hw/filt_pkg.sv
hw/safe_alu.sv
hw/coef_regs.sv
hw/ema_stage.sv
hw/gain_stage.sv
hw/fxp_filter_top.sv
tb/tb_fxp_filter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the filter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_fxp_filter \
  -f sources.f \
  --Mdir obj_dir -o tb_fxp_filter

sim_out=$(./obj_dir/tb_fxp_filter)
echo "$sim_out"

if echo "$sim_out" | grep -q "No errors"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
